//--- list.f
+incdir+hdl
hdl/audio_pkg.sv
hdl/digimax_dac.sv
hdl/fm_compressor.sv
hdl/audio_mixer.sv
hdl/c64_audio_top.sv
testbench/tb_clock.sv
testbench/tb_audio_top.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_audio_top
LIST  = list.f
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(LIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(LIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_audio_top.sv
/* Audio path testbench */

`timescale 1ns/10ps

`include "audio_cfg.svh"

module tb_audio_top
	import audio_pkg::*;
();

	// Compressor curve as given for the audio path
	localparam int KNEE = (32767 * 3) / 7 + 1;
	localparam int BASE = 2 * KNEE;

	logic clk_sys;
	logic RESET;
	cpu_bus_t bus;
	digimax_mode_t mode;
	sample_t fm;
	sid_pair_t sid;
	logic cass;
	audio_pair_t audio_o;

	int seed = 32'h9a90_d92f;
	int err_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int err_start = 0;

	// Reference pipeline state
	cpu_bus_t b1;
	cpu_bus_t b2;
	logic r_stb;
	logic [2:0] r_waddr;
	logic [7:0] r_wdata;
	int ref_reg [4];
	logic [3:0] ref_act;
	int r_dac_l;
	int r_dac_r;
	int r_att;
	int r_fmc;
	int r_sum_l;
	int r_sum_r;
	int exp_l;
	int exp_r;

	tb_clock tb_clock_inst (.clk_o(clk_sys), .reset_o(RESET));

	c64_audio_top c64_audio_top_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.bus_i          (bus),
		.digimax_mode_i (mode),
		.fm_i           (fm),
		.sid_i          (sid),
		.cass_snd_i     (cass),
		.audio_o        (audio_o)
	);

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic logic watched(input cpu_bus_t b, input digimax_mode_t m);
		if (m == 2'd0)
			return 1'b0;
		return (m == 2'd1) ? b.io_e : b.io_f;
	endfunction

	function automatic int compress_ref(input int x);
		int v;
		int r;
		v = (x < 0) ? -x : x;
		r = (v < KNEE) ? v * 2 : (v - KNEE) / 4 + BASE;
		return (x < 0) ? -r : r;
	endfunction

	function automatic int dac_side(input logic [3:0] act, input int c0, input int c1,
		input int c2, input int c3, input logic left);
		if (act < 2)
			return 2 * c0;
		if (act == 2)
			return left ? 2 * c1 : 2 * c0;
		return left ? c1 + c2 : c0 + c3;
	endfunction

	// 17-bit wrapping sum of all four sources
	function automatic int mix_sum(input int f, input int s, input int d, input logic c);
		int total;
		logic signed [16:0] w;
		total = f + (s >>> 2) + d * 64 + (c ? 1024 : 0);
		w = total[16:0];
		return int'(w);
	endfunction

	function automatic int clamp(input int s);
		if (s > 32767)
			return 32767;
		if (s < -32768)
			return -32768;
		return s;
	endfunction

	always @(posedge clk_sys) begin
		if (RESET) begin
			b1 <= '0;
			b2 <= '0;
			r_stb <= 1'b0;
			r_waddr <= '0;
			r_wdata <= '0;
			for (int i = 0; i < 4; i++)
				ref_reg[i] <= 0;
			ref_act <= '0;
			{r_dac_l, r_dac_r, r_att, r_fmc} <= '0;
			{r_sum_l, r_sum_r, exp_l, exp_r} <= '0;
		end else begin
			b1 <= bus;
			b2 <= b1;
			r_stb <= watched(b1, mode) && !watched(b2, mode) && b1.wr;
			r_waddr <= b1.addr;
			r_wdata <= b1.data;
			if (mode == 2'd0) begin
				for (int i = 0; i < 4; i++)
					ref_reg[i] <= 0;
				ref_act <= '0;
			end else if (r_stb && !r_waddr[2]) begin
				ref_reg[r_waddr[1:0]] <= int'(r_wdata);
				if (r_wdata != 0)
					ref_act[r_waddr[1:0]] <= 1'b1;
			end
			r_dac_l <= dac_side(ref_act, ref_reg[0], ref_reg[1], ref_reg[2],
				ref_reg[3], 1'b1);
			r_dac_r <= dac_side(ref_act, ref_reg[0], ref_reg[1], ref_reg[2],
				ref_reg[3], 1'b0);
			r_att <= int'(fm) - (int'(fm) >>> 3);
			r_fmc <= compress_ref(r_att);
			r_sum_l <= mix_sum(r_fmc, int'(sid.left), r_dac_l, cass);
			r_sum_r <= mix_sum(r_fmc, int'(sid.right), r_dac_r, cass);
			exp_l <= clamp(r_sum_l);
			exp_r <= clamp(r_sum_r);
		end
	end

	a_audio_left: assert property (@(posedge clk_sys) disable iff (RESET)
		int'(audio_o.left) == exp_l)
		else begin
			$display("Error: time %0t audio_o.left got %0d expected %0d",
				$time, $sampled(audio_o.left), $sampled(exp_l));
			err_count++;
		end

	a_audio_right: assert property (@(posedge clk_sys) disable iff (RESET)
		int'(audio_o.right) == exp_r)
		else begin
			$display("Error: time %0t audio_o.right got %0d expected %0d",
				$time, $sampled(audio_o.right), $sampled(exp_r));
			err_count++;
		end

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic settle(input int l, input int r, input string what);
		int n;
		n = 0;
		while (!(int'(audio_o.left) == l && int'(audio_o.right) == r) && n < 30) begin
			next_cycle();
			n++;
		end
		if (n >= 30) begin
			$display("%s: audio output never reached %0d / %0d", what, l, r);
			err_count++;
		end
	endtask

	task automatic cpu_write(input logic use_f, input logic [2:0] addr,
		input logic [7:0] data);
		bus.io_e = !use_f;
		bus.io_f = use_f;
		bus.wr = 1'b1;
		bus.addr = addr;
		bus.data = data;
		next_cycle();
		bus = '0;
		next_cycle();
	endtask

	task automatic set_mode(input digimax_mode_t m);
		mode = m;
		idle(3);
	endtask

	task automatic start_test();
		err_start = err_count;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (err_count == err_start) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			$display("Test %0d %s: FAILED with %0d errors", tests_run, name,
				err_count - err_start);
			tests_failed++;
		end
	endtask

	task automatic digimax_run(input digimax_mode_t m, input logic use_f);
		set_mode(2'd0);
		set_mode(m);
		// Mono from channel 0
		cpu_write(use_f, 3'd0, 8'h40);
		settle(8192, 8192, "DigiMax mono");
		// Ignored writes
		cpu_write(use_f, 3'd4, 8'h11);
		cpu_write(!use_f, 3'd0, 8'h7f);
		idle(8);
		settle(8192, 8192, "DigiMax ignored write");
		// Held select lets only the first edge count
		bus.io_e = !use_f;
		bus.io_f = use_f;
		bus.wr = 1'b1;
		bus.data = 8'h30;
		next_cycle();
		bus.data = 8'h55;
		idle(4);
		bus = '0;
		idle(8);
		settle(6144, 6144, "DigiMax held select");
		// Stereo from channel 1 alone
		set_mode(2'd0);
		set_mode(m);
		cpu_write(use_f, 3'd1, 8'h20);
		settle(4096, 0, "DigiMax stereo");
		// All four channels
		cpu_write(use_f, 3'd0, 8'h10);
		cpu_write(use_f, 3'd2, 8'h08);
		cpu_write(use_f, 3'd3, 8'h04);
		settle(2560, 1280, "DigiMax four channels");
		set_mode(2'd0);
		settle(0, 0, "DigiMax cleared");
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	initial begin
		int n;
		int specials [10];
		specials = '{14043, 14044, 14045, 16049, 16050, 16051, 32767, -32767, -16050, 0};
		bus = '0;
		mode = 2'd0;
		fm = '0;
		sid = '0;
		cass = 1'b0;

		n = 0;
		while (RESET !== 1'b0 && n < 100) begin
			@(posedge clk_sys);
			n++;
		end
		if (RESET !== 1'b0) begin
			$display("Reset was never released");
			err_count++;
		end
		#5;

		start_test();
		idle(6);
		settle(0, 0, "Reset state");
		end_test("reset state");

		start_test();
		repeat (40) begin
			sid.left = sid_sample_t'($random(seed));
			sid.right = sid_sample_t'($random(seed));
			next_cycle();
		end
		sid = '0;
		settle(0, 0, "SID path");
		end_test("SID path");

		start_test();
		foreach (specials[i]) begin
			fm = sample_t'(specials[i]);
			next_cycle();
		end
		repeat (40) begin
			fm = sample_t'($random(seed));
			next_cycle();
		end
		fm = 16'sd16050;
		settle(28088, 28088, "FM knee");
		fm = '0;
		settle(0, 0, "FM path");
		end_test("FM compression");

		start_test();
		digimax_run(2'd1, 1'b0);
		digimax_run(2'd2, 1'b1);
		end_test("DigiMax modes");

		start_test();
		set_mode(2'd1);
		cpu_write(1'b0, 3'd0, 8'h40);
		settle(8192, 8192, "DigiMax enabled");
		set_mode(2'd0);
		settle(0, 0, "DigiMax disabled");
		cpu_write(1'b0, 3'd0, 8'h22);
		cpu_write(1'b1, 3'd1, 8'h33);
		set_mode(2'd1);
		idle(8);
		settle(0, 0, "DigiMax writes while disabled");
		set_mode(2'd0);
		end_test("DigiMax disable");

		start_test();
		cass = 1'b1;
		settle(1024, 1024, "Cassette tone");
		cass = 1'b0;
		fm = 16'sd32767;
		sid.left = 18'h1ffff;
		sid.right = 18'h1ffff;
		settle(32767, 32767, "Positive saturation");
		fm = -16'sd32768;
		sid.left = 18'h20000;
		sid.right = 18'h20000;
		settle(-32768, -32768, "Negative saturation");
		fm = '0;
		sid = '0;
		settle(0, 0, "Saturation release");
		end_test("cassette and saturation");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Backstop if a loop above ever stalls
	initial begin
		#1_000_000;
		$display("Simulation ran past its time limit");
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- testbench/tb_clock.sv
/* Testbench clock and reset */

`timescale 1ns/10ps

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	// 100 ns period
	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// Reset held for 8 rising edges, released just after an edge
	initial begin
		reset_o = 1'b1;
		repeat (8) @(posedge clk_o);
		#5 reset_o = 1'b0;
	end

endmodule

//--- hdl/c64_audio_top.sv
/* Audio output path top level */

`timescale 1ns/10ps

module c64_audio_top
	import audio_pkg::*;
(
	input  logic          clk_sys,
	input  logic          RESET,
	input  cpu_bus_t      bus_i,
	input  digimax_mode_t digimax_mode_i,
	input  sample_t       fm_i,
	input  sid_pair_t     sid_i,
	input  logic          cass_snd_i,
	output audio_pair_t   audio_o
);

	dac_pair_t dac_level;
	sample_t fm_comp;

	// ========================================================================
	// Sources
	// ========================================================================

	// CPU writes reach the mix five edges later
	digimax_dac digimax_dac_inst (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.bus_i   (bus_i),
		.mode_i  (digimax_mode_i),
		.dac_o   (dac_level)
	);

	fm_compressor fm_compressor_inst (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.fm_i    (fm_i),
		.fm_o    (fm_comp)
	);

	// ========================================================================
	// Final mix
	// ========================================================================

	// SID and cassette enter here directly
	audio_mixer audio_mixer_inst (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.fm_i    (fm_comp),
		.sid_i   (sid_i),
		.dac_i   (dac_level),
		.cass_i  (cass_snd_i),
		.audio_o (audio_o)
	);

endmodule

//--- hdl/audio_mixer.sv
/* Stereo audio mixer with saturation */

`timescale 1ns/10ps

`include "audio_cfg.svh"

module audio_mixer
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  sample_t     fm_i,
	input  sid_pair_t   sid_i,
	input  dac_pair_t   dac_i,
	input  logic        cass_i,
	output audio_pair_t audio_o
);

	// One guard bit over the output width
	localparam int SUM_W = `SAMPLE_W + 1;
	localparam sample_t MAX_S = {1'b0, {(`SAMPLE_W-1){1'b1}}};
	localparam sample_t MIN_S = {1'b1, {(`SAMPLE_W-1){1'b0}}};

	typedef struct packed {
		logic [SUM_W-1:0] left;
		logic [SUM_W-1:0] right;
	} sum_pair_t;

	sum_pair_t sum_q;

	function automatic logic [SUM_W-1:0] side_sum(input sample_t fm,
		input sid_sample_t sid, input dac_level_t dac, input logic cass);
		logic [SUM_W-1:0] cass_term;
		cass_term = '0;
		cass_term[`CASS_SHIFT] = cass;
		side_sum = {fm[`SAMPLE_W-1], fm}
			+ {sid[`SID_W-1], sid[`SID_W-1:2]}
			+ {2'b00, dac, {`DAC_SHIFT{1'b0}}}
			+ cass_term;
	endfunction

	// Top two bits differ on overflow
	function automatic sample_t saturate(input logic [SUM_W-1:0] s);
		if (s[SUM_W-1] ^ s[SUM_W-2])
			saturate = s[SUM_W-1] ? MIN_S : MAX_S;
		else
			saturate = s[SUM_W-2:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sum_q <= '0;
			audio_o <= '0;
		end else begin
			sum_q.left <= side_sum(fm_i, sid_i.left, dac_i.left, cass_i);
			sum_q.right <= side_sum(fm_i, sid_i.right, dac_i.right, cass_i);
			audio_o.left <= saturate(sum_q.left);
			audio_o.right <= saturate(sum_q.right);
		end
	end

	a_sat_left: assert property (@(posedge clk_sys) disable iff (RESET)
		(^sum_q.left[SUM_W-1 -: 2]) |=>
		(audio_o.left == ($past(sum_q.left[SUM_W-1]) ? MIN_S : MAX_S)));

	a_sat_right: assert property (@(posedge clk_sys) disable iff (RESET)
		(^sum_q.right[SUM_W-1 -: 2]) |=>
		(audio_o.right == ($past(sum_q.right[SUM_W-1]) ? MIN_S : MAX_S)));

endmodule

//--- hdl/fm_compressor.sv
/* FM attenuation and soft compressor */

`timescale 1ns/10ps

`include "audio_cfg.svh"

module fm_compressor
	import audio_pkg::*;
(
	input  logic    clk_sys,
	input  logic    RESET,
	input  sample_t fm_i,
	output sample_t fm_o
);

	localparam logic [`SAMPLE_W-1:0] KNEE = COMP_KNEE[`SAMPLE_W-1:0];
	localparam logic [`SAMPLE_W-1:0] BASE = COMP_BASE[`SAMPLE_W-1:0];
	localparam logic [`SAMPLE_W-1:0] GAIN = `COMP_GAIN;
	localparam logic [`SAMPLE_W-1:0] FACTOR = `COMP_FACTOR;

	sample_t atten_q;

	// ========================================================================
	// Two-segment curve on the magnitude
	// ========================================================================

	function automatic sample_t compress(input sample_t x);
		logic [`SAMPLE_W-1:0] mag;
		logic [`SAMPLE_W-1:0] res;
		mag = x[`SAMPLE_W-1] ? (~x) + 1'b1 : x;
		if (mag < KNEE)
			res = mag * GAIN;
		else
			res = ((mag - KNEE) / FACTOR) + BASE;
		// Sign goes back on after the curve
		compress = x[`SAMPLE_W-1] ? (~res) + 1'b1 : res;
	endfunction

	// Stage 1 takes an eighth off the sample
	always_ff @(posedge clk_sys) begin
		if (RESET)
			atten_q <= '0;
		else
			atten_q <= fm_i - (fm_i >>> 3);
	end

	// Stage 2
	always_ff @(posedge clk_sys) begin
		if (RESET)
			fm_o <= '0;
		else
			fm_o <= compress(atten_q);
	end

	// Attenuation keeps the curve clear of the negative limit
	a_fm_range: assert property (@(posedge clk_sys) disable iff (RESET)
		fm_o != {1'b1, {(`SAMPLE_W-1){1'b0}}});

endmodule

//--- hdl/digimax_dac.sv
/* DigiMax four-channel sample DAC */

`timescale 1ns/10ps

`include "audio_cfg.svh"

module digimax_dac
	import audio_pkg::*;
(
	input  logic          clk_sys,
	input  logic          RESET,
	input  cpu_bus_t      bus_i,
	input  digimax_mode_t mode_i,
	output dac_pair_t     dac_o
);

	// Registered bus and the select levels one edge before it
	cpu_bus_t bus_q;
	logic io_e_prev;
	logic io_f_prev;

	// Watched page for the current mode
	logic sel_now;
	logic sel_prev;

	logic wr_stb;
	logic [2:0] wr_addr;
	logic [`DAC_W-1:0] wr_data;

	logic [`DAC_W-1:0] dac_reg [`DAC_CHANNELS];
	logic [`DAC_CHANNELS-1:0] act;

	function automatic dac_level_t add_ch(input logic [`DAC_W-1:0] a,
		input logic [`DAC_W-1:0] b);
		add_ch = {1'b0, a} + {1'b0, b};
	endfunction

	// ========================================================================
	// Write detection
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bus_q <= '0;
			io_e_prev <= 1'b0;
			io_f_prev <= 1'b0;
		end else begin
			bus_q <= bus_i;
			io_e_prev <= bus_q.io_e;
			io_f_prev <= bus_q.io_f;
		end
	end

	always_comb begin
		case (mode_i)
			2'd0: begin
				sel_now = 1'b0;
				sel_prev = 1'b0;
			end
			2'd1: begin
				sel_now = bus_q.io_e;
				sel_prev = io_e_prev;
			end
			default: begin
				sel_now = bus_q.io_f;
				sel_prev = io_f_prev;
			end
		endcase
	end

	// Address and data travel with the strobe
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_stb <= 1'b0;
			wr_addr <= '0;
			wr_data <= '0;
		end else begin
			wr_stb <= sel_now & ~sel_prev & bus_q.wr;
			wr_addr <= bus_q.addr;
			wr_data <= bus_q.data;
		end
	end

	// ========================================================================
	// Register file and channel-mode guess
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET || mode_i == 2'd0) begin
			for (int i = 0; i < `DAC_CHANNELS; i++) begin
				dac_reg[i] <= '0;
			end
			act <= '0;
		end else if (wr_stb && !wr_addr[2]) begin
			dac_reg[wr_addr[1:0]] <= wr_data;
			if (wr_data != '0)
				act[wr_addr[1:0]] <= 1'b1;
		end
	end

	// Mono below 2, stereo at 2, four channels otherwise
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dac_o <= '0;
		end else if (act < 2) begin
			dac_o.left <= add_ch(dac_reg[0], dac_reg[0]);
			dac_o.right <= add_ch(dac_reg[0], dac_reg[0]);
		end else if (act == 2) begin
			dac_o.left <= add_ch(dac_reg[1], dac_reg[1]);
			dac_o.right <= add_ch(dac_reg[0], dac_reg[0]);
		end else begin
			dac_o.left <= add_ch(dac_reg[1], dac_reg[2]);
			dac_o.right <= add_ch(dac_reg[0], dac_reg[3]);
		end
	end

	// Disabling the DAC forgets every channel seen so far
	a_act_cleared: assert property (@(posedge clk_sys) disable iff (RESET)
		(mode_i == 2'd0) |=> (act == '0));

endmodule

//--- hdl/audio_pkg.sv
/* Audio path types */

`include "audio_cfg.svh"

package audio_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;
	typedef logic signed [`SID_W-1:0] sid_sample_t;
	// Sum of two DAC registers
	typedef logic [`DAC_W:0] dac_level_t;
	// 0 off, 1 IOE page, 2 and 3 IOF page
	typedef logic [1:0] digimax_mode_t;

	typedef struct packed {
		logic io_e;
		logic io_f;
		logic wr;
		logic [2:0] addr;
		logic [`DAC_W-1:0] data;
	} cpu_bus_t;

	typedef struct packed {sid_sample_t left; sid_sample_t right;} sid_pair_t;
	typedef struct packed {dac_level_t left; dac_level_t right;} dac_pair_t;
	typedef struct packed {sample_t left; sample_t right;} audio_pair_t;

	// Knee sits where both segments meet below full scale
	localparam int COMP_KNEE =
		((32767 * (`COMP_FACTOR - 1)) / ((`COMP_FACTOR * `COMP_GAIN) - 1)) + 1;
	localparam int COMP_BASE = COMP_KNEE * `COMP_GAIN;

endpackage

//--- hdl/audio_cfg.svh
/* Audio path widths and compressor constants */

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// ===========================================================================
// Sample widths
// ===========================================================================

// FM samples and final audio outputs
`define SAMPLE_W 16
// SID voice-chip samples
`define SID_W 18

// ===========================================================================
// DigiMax
// ===========================================================================

`define DAC_W 8
`define DAC_CHANNELS 4
// Position of a DAC sum inside the mix
`define DAC_SHIFT 6

// Slope divisor above the knee
`define COMP_FACTOR 4
// Gain below the knee
`define COMP_GAIN 2

// Bit weight of the cassette tone
`define CASS_SHIFT 10

`endif
